// ==== issue_core.f ====
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/inst_decoder.sv
rtl/issue_ctrl.sv
rtl/reg_file.sv
rtl/alu_unit.sv
rtl/exec_unit0.sv
rtl/issue_core.sv
tb/tb_issue_core.sv

// ==== rtl/alu_unit.sv ====
`default_nettype none

module alu_unit (
    input  wire isa_pkg::opcode_e          op,
    input  wire logic [isa_pkg::xlen-1:0]  a,
    input  wire logic [isa_pkg::xlen-1:0]  b,
    input  wire logic [isa_pkg::xlen-1:0]  imm,
    output logic [isa_pkg::xlen-1:0]       result
);

    import isa_pkg::*;

    always_comb begin
        case (op)
            op_add:  result = a + b;
            op_sub:  result = a - b;
            op_and:  result = a & b;
            op_or:   result = a | b;
            op_xor:  result = a ^ b;
            // imm arrives already extended
            op_addi: result = a + imm;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/exec_unit0.sv ====
`default_nettype none

module exec_unit0 (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      en,
    input  wire pipe_pkg::issue_slot_t     slot,
    input  wire logic [isa_pkg::xlen-1:0]  a,
    input  wire logic [isa_pkg::xlen-1:0]  b,
    output logic                           ready,
    output pipe_pkg::wb_t                  wb,
    output logic                           exc_valid,
    output logic [isa_pkg::xlen-1:0]       exc_pc,
    output pipe_pkg::exc_e                 exc_code
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       mul_prod;
    logic [reg_addr_w-1:0] mul_rd;
    logic [mul_cnt_w-1:0]  mul_cnt;
    logic                  legal;
    logic                  start_mul;
    logic                  mul_done;

    alu_unit alu_inst (
        .op     (slot.opcode),
        .a      (a),
        .b      (b),
        .imm    (slot.imm),
        .result (alu_result)
    );

    assign legal     = (slot.exc == exc_none);
    assign start_mul = en && legal && (slot.opcode == op_mul);
    // last busy cycle
    assign mul_done  = (mul_cnt == mul_cnt_w'(1));

    // counts down the busy cycles after issue
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_cnt <= '0;
        end else if (start_mul) begin
            mul_cnt <= mul_cnt_w'(mul_latency - 1);
        end else if (mul_cnt != '0) begin
            mul_cnt <= mul_cnt - 1'b1;
        end
    end

    // product kept until write-back, low word only
    always_ff @(posedge clk) begin
        if (start_mul) begin
            mul_prod <= a * b;
            mul_rd   <= slot.rd;
        end
    end

    assign ready = (mul_cnt == '0);

    always_comb begin
        if (mul_done) begin
            wb.valid = 1'b1;
            wb.rd    = mul_rd;
            wb.data  = mul_prod;
        end else begin
            // no write for nops and exceptions
            wb.valid = en && legal && is_alu_op(slot.opcode);
            wb.rd    = slot.rd;
            wb.data  = alu_result;
        end
    end

    assign exc_valid = en && !legal;
    assign exc_pc    = slot.pc;
    assign exc_code  = slot.exc;

endmodule

`default_nettype wire

// ==== rtl/inst_decoder.sv ====
`default_nettype none

module inst_decoder (
    input  wire isa_pkg::instr_t           instr0,
    input  wire isa_pkg::instr_t           instr1,
    input  wire logic [isa_pkg::xlen-1:0]  pc0,
    input  wire logic [isa_pkg::xlen-1:0]  pc1,
    input  wire logic                      valid0,
    input  wire logic                      valid1,
    output pipe_pkg::issue_slot_t          slot0,
    output pipe_pkg::issue_slot_t          slot1
);

    import isa_pkg::*;
    import pipe_pkg::*;

    issue_slot_t dec0;
    issue_slot_t dec1;

    function automatic issue_slot_t decode(instr_t instr, logic [xlen-1:0] pc, logic valid);
        issue_slot_t s;
        logic        legal;

        legal    = is_legal_op(instr.opcode);
        s.valid  = valid;
        // illegal codes travel as nop with the exception attached
        s.opcode = legal ? opcode_e'(instr.opcode) : op_nop;
        s.rd     = instr.rd;
        s.rj     = instr.rj;
        s.rk     = instr.rk;
        if (s.opcode == op_addi) begin
            s.imm = {{(xlen - imm_w){instr.imm[imm_w-1]}}, instr.imm};
        end else begin
            s.imm = {{(xlen - imm_w){1'b0}}, instr.imm};
        end
        s.pc  = pc;
        s.exc = legal ? exc_none : exc_illegal;
        return s;
    endfunction

    assign dec0 = decode(instr0, pc0, valid0);
    assign dec1 = decode(instr1, pc1, valid1);

    // word 1 moves up over a bubble in word 0
    assign slot0 = valid0 ? dec0 : dec1;
    // slot 1 always carries word 1, so a moved word shows up in both slots
    assign slot1 = dec1;

endmodule

`default_nettype wire

// ==== rtl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int opcode_w   = 6;
    localparam int imm_w      = 11;

    typedef enum logic [opcode_w-1:0] {
        op_nop  = 6'd0,
        op_add  = 6'd1,
        op_sub  = 6'd2,
        op_and  = 6'd3,
        op_or   = 6'd4,
        op_xor  = 6'd5,
        op_addi = 6'd6,
        op_mul  = 6'd7
    } opcode_e;

    // raw instruction word, opcode in the top bits
    typedef struct packed {
        logic [opcode_w-1:0]   opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rk;
        logic [imm_w-1:0]      imm;
    } instr_t;

    // any code outside the enum is illegal
    function automatic logic is_legal_op(logic [opcode_w-1:0] code);
        return code inside {op_nop, op_add, op_sub, op_and, op_or, op_xor, op_addi, op_mul};
    endfunction

    // ops that unit 1 can run
    function automatic logic is_alu_op(opcode_e op);
        return op inside {op_add, op_sub, op_and, op_or, op_xor, op_addi};
    endfunction

endpackage

`default_nettype wire

// ==== rtl/issue_core.sv ====
`default_nettype none

module issue_core (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      flush,
    input  wire isa_pkg::instr_t           fetch_instr0,
    input  wire isa_pkg::instr_t           fetch_instr1,
    input  wire logic [isa_pkg::xlen-1:0]  fetch_pc0,
    input  wire logic [isa_pkg::xlen-1:0]  fetch_pc1,
    input  wire logic                      fetch_valid0,
    input  wire logic                      fetch_valid1,
    output logic [1:0]                     num_read,
    output pipe_pkg::wb_t                  wb0,
    output pipe_pkg::wb_t                  wb1,
    output logic                           exc_valid,
    output logic [isa_pkg::xlen-1:0]       exc_pc,
    output pipe_pkg::exc_e                 exc_code
);

    import isa_pkg::*;
    import pipe_pkg::*;

    issue_slot_t     dec_slot0;
    issue_slot_t     dec_slot1;
    issue_slot_t     eu0_slot;
    issue_slot_t     eu1_slot;
    logic            eu0_en;
    logic            eu1_en;
    logic            eu0_ready;
    logic            eu1_ready;
    logic [xlen-1:0] eu0_a;
    logic [xlen-1:0] eu0_b;
    logic [xlen-1:0] eu1_a;
    logic [xlen-1:0] eu1_b;
    logic [xlen-1:0] eu1_result;

    inst_decoder decoder_inst (
        .instr0 (fetch_instr0),
        .instr1 (fetch_instr1),
        .pc0    (fetch_pc0),
        .pc1    (fetch_pc1),
        .valid0 (fetch_valid0),
        .valid1 (fetch_valid1),
        .slot0  (dec_slot0),
        .slot1  (dec_slot1)
    );

    issue_ctrl issue_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .slot0     (dec_slot0),
        .slot1     (dec_slot1),
        .eu0_ready (eu0_ready),
        .eu1_ready (eu1_ready),
        .num_read  (num_read),
        .eu0_en    (eu0_en),
        .eu1_en    (eu1_en),
        .eu0_slot  (eu0_slot),
        .eu1_slot  (eu1_slot)
    );

    // operands read straight from the buffer entries
    reg_file rf_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .ra0   (eu0_slot.rj),
        .ra1   (eu0_slot.rk),
        .ra2   (eu1_slot.rj),
        .ra3   (eu1_slot.rk),
        .wr0   (wb0),
        .wr1   (wb1),
        .rd0   (eu0_a),
        .rd1   (eu0_b),
        .rd2   (eu1_a),
        .rd3   (eu1_b)
    );

    exec_unit0 eu0_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (eu0_en),
        .slot      (eu0_slot),
        .a         (eu0_a),
        .b         (eu0_b),
        .ready     (eu0_ready),
        .wb        (wb0),
        .exc_valid (exc_valid),
        .exc_pc    (exc_pc),
        .exc_code  (exc_code)
    );

    // unit 1 is a bare ALU with no state
    alu_unit eu1_inst (
        .op     (eu1_slot.opcode),
        .a      (eu1_a),
        .b      (eu1_b),
        .imm    (eu1_slot.imm),
        .result (eu1_result)
    );

    assign eu1_ready = 1'b1;
    assign wb1       = '{valid: eu1_en, rd: eu1_slot.rd, data: eu1_result};

endmodule

`default_nettype wire

// ==== rtl/issue_ctrl.sv ====
`default_nettype none

module issue_ctrl (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   flush,
    input  wire pipe_pkg::issue_slot_t  slot0,
    input  wire pipe_pkg::issue_slot_t  slot1,
    input  wire logic                   eu0_ready,
    input  wire logic                   eu1_ready,
    output logic [1:0]                  num_read,
    output logic                        eu0_en,
    output logic                        eu1_en,
    output pipe_pkg::issue_slot_t       eu0_slot,
    output pipe_pkg::issue_slot_t       eu1_slot
);

    import isa_pkg::*;
    import pipe_pkg::*;

    issue_slot_t entry0;
    issue_slot_t entry1;
    logic [1:0]  fill;
    logic [1:0]  fill_left;
    logic        issue0;
    logic        issue1;
    logic        raw_hazard;
    logic        slot1_dup;
    logic        word0_live;
    logic        take_second;

    // entry 1 reads what entry 0 writes in the same cycle
    assign raw_hazard = (entry0.rd != '0)
                        && ((entry0.rd == entry1.rj) || (entry0.rd == entry1.rk));

    assign issue0 = eu0_ready && (fill != 2'd0) && entry0.valid;

    // a multiply in entry 0 writes back later, so nothing younger may go beside it
    assign issue1 = issue0 && eu1_ready && (fill == 2'd2) && entry1.valid
                    && is_alu_op(entry1.opcode) && (entry0.opcode != op_mul)
                    && !raw_hazard;

    assign eu0_en   = issue0;
    assign eu1_en   = issue1;
    assign eu0_slot = entry0;
    assign eu1_slot = entry1;

    always_comb begin
        case ({issue1, issue0})
            2'b01:   fill_left = fill - 2'd1;
            2'b11:   fill_left = fill - 2'd2;
            default: fill_left = fill;
        endcase
    end

    always_comb begin
        case (fill_left)
            2'd2:    num_read = 2'b00;
            2'd1:    num_read = 2'b01;
            default: num_read = 2'b11;
        endcase
    end

    // equal slots mean the decoder moved word 1 over a bubble in word 0
    assign slot1_dup   = slot1.valid && (slot0 == slot1);
    assign word0_live  = slot0.valid && !slot1_dup;
    assign take_second = slot1.valid && !slot1_dup;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            fill <= 2'd0;
        end else begin
            case (fill_left)
                2'd0:    fill <= {1'b0, slot0.valid} + {1'b0, take_second};
                2'd1:    fill <= word0_live ? 2'd2 : 2'd1;
                default: fill <= fill_left;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (fill_left)
            2'd0: begin
                entry0 <= slot0;
                entry1 <= slot1;
            end
            2'd1: begin
                // the survivor moves to the head
                if (issue0) begin
                    entry0 <= entry1;
                end
                // only word 0 is consumed here
                entry1 <= slot0;
            end
            default: begin
                entry0 <= entry0;
                entry1 <= entry1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    // cycles from multiply issue to its write-back, counting the issue cycle
    localparam int mul_latency = 3;
    localparam int mul_cnt_w   = $clog2(mul_latency);

    typedef enum logic [1:0] {
        exc_none    = 2'd0,
        exc_illegal = 2'd1
    } exc_e;

    // one decoded instruction as it sits in the issue buffer
    typedef struct packed {
        logic                           valid;
        isa_pkg::opcode_e               opcode;
        logic [isa_pkg::reg_addr_w-1:0] rd;
        logic [isa_pkg::reg_addr_w-1:0] rj;
        logic [isa_pkg::reg_addr_w-1:0] rk;
        logic [isa_pkg::xlen-1:0]       imm;
        logic [isa_pkg::xlen-1:0]       pc;
        exc_e                           exc;
    } issue_slot_t;

    // register write, also the write-back strobe
    typedef struct packed {
        logic                           valid;
        logic [isa_pkg::reg_addr_w-1:0] rd;
        logic [isa_pkg::xlen-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none

module reg_file (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic [isa_pkg::reg_addr_w-1:0] ra0,
    input  wire logic [isa_pkg::reg_addr_w-1:0] ra1,
    input  wire logic [isa_pkg::reg_addr_w-1:0] ra2,
    input  wire logic [isa_pkg::reg_addr_w-1:0] ra3,
    input  wire pipe_pkg::wb_t                 wr0,
    input  wire pipe_pkg::wb_t                 wr1,
    output logic [isa_pkg::xlen-1:0]           rd0,
    output logic [isa_pkg::xlen-1:0]           rd1,
    output logic [isa_pkg::xlen-1:0]           rd2,
    output logic [isa_pkg::xlen-1:0]           rd3
);

    import isa_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // register zero is never written
            if (wr0.valid && (wr0.rd != '0)) begin
                regs[wr0.rd] <= wr0.data;
            end
            // port 1 comes last, the younger write wins
            if (wr1.valid && (wr1.rd != '0)) begin
                regs[wr1.rd] <= wr1.data;
            end
        end
    end

    assign rd0 = regs[ra0];
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];
    assign rd3 = regs[ra3];

endmodule

`default_nettype wire

// ==== tb/tb_issue_core.sv ====
`default_nettype none

module tb_issue_core;

    timeunit 1ns;
    timeprecision 100ps;

    import isa_pkg::*;
    import pipe_pkg::*;

    // expected strobe for a register write or an exception
    typedef struct packed {
        logic        is_exc;
        logic        is_mul;
        logic [4:0]  rd;
        logic [31:0] value;
    } event_t;

    localparam int total_words  = 200;
    localparam int num_tests    = 6;
    localparam int watchdog_ns  = (total_words * 40 + num_tests * 40) * 20;
    localparam int mul_wb_delay = 2;
    localparam int flush_mark   = 20;

    logic        clk;
    logic        rst_n;
    logic        flush;
    instr_t      fetch_instr0;
    instr_t      fetch_instr1;
    logic [31:0] fetch_pc0;
    logic [31:0] fetch_pc1;
    logic        fetch_valid0;
    logic        fetch_valid1;
    logic [1:0]  num_read;
    wb_t         wb0;
    wb_t         wb1;
    logic        exc_valid;
    logic [31:0] exc_pc;
    exc_e        exc_code;

    instr_t      prog_w [64];
    logic        prog_v [64];
    int          prog_len;
    logic [31:0] mregs [32];
    event_t      exp_q [$];
    int          exp_pos;
    int          errors;
    int          failed_tests;
    int          dual_cnt;
    int          cyc;
    int          mul_issue_cyc;
    logic        flush_done;
    int          flush_k;
    logic [15:0] lfsr = 16'd20111;

    issue_core issue_core_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .fetch_instr0 (fetch_instr0),
        .fetch_instr1 (fetch_instr1),
        .fetch_pc0    (fetch_pc0),
        .fetch_pc1    (fetch_pc1),
        .fetch_valid0 (fetch_valid0),
        .fetch_valid1 (fetch_valid1),
        .num_read     (num_read),
        .wb0          (wb0),
        .wb1          (wb1),
        .exc_valid    (exc_valid),
        .exc_pc       (exc_pc),
        .exc_code     (exc_code)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 16'hb400;
            end
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic instr_t mk_instr(input logic [5:0] op, input logic [4:0] rd,
                                        input logic [4:0] rj, input logic [4:0] rk,
                                        input logic [10:0] imm);
        instr_t w;
        w.opcode = op;
        w.rd     = rd;
        w.rj     = rj;
        w.rk     = rk;
        w.imm    = imm;
        return w;
    endfunction

    function automatic logic [5:0] rand_alu_op();
        return 6'(32'd1 + rand_bits(3) % 6);
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [4:0] r;
        r = 5'(rand_bits(4));
        if (r == '0) begin
            r = 5'd1;
        end
        return r;
    endfunction

    function automatic void add_word(input instr_t w, input logic v);
        prog_w[prog_len] = w;
        prog_v[prog_len] = v;
        prog_len++;
    endfunction

    function automatic void build_program(input int id);
        instr_t     w;
        logic [4:0] prev_rd;
        logic [5:0] op;
        prog_len = 0;
        // load nonzero values since reset clears the registers
        for (int i = 0; i < 8; i++) begin
            add_word(mk_instr(op_addi, 5'(i + 1), 5'd0, 5'd0, 11'(rand_bits(11))), 1'b1);
        end
        case (id)
            1, 2: begin
                if (id == 2) begin
                    // still aligned to pairs here, older word writes r0 and younger reads it
                    add_word(mk_instr(op_add, 5'd0, 5'd1, 5'd2, 11'd0), 1'b1);
                    add_word(mk_instr(op_addi, 5'd9, 5'd0, 5'd0, 11'h7f5), 1'b1);
                    add_word(mk_instr(op_xor, 5'd0, 5'd3, 5'd4, 11'd0), 1'b1);
                    add_word(mk_instr(op_or, 5'd10, 5'd0, 5'd5, 11'd0), 1'b1);
                end
                for (int i = 0; i < ((id == 1) ? 12 : 10); i++) begin
                    w = mk_instr(rand_alu_op(), rand_reg(), rand_reg(), rand_reg(),
                                 11'(rand_bits(11)));
                    add_word(w, 1'b1);
                    prev_rd = w.rd;
                    w = mk_instr(rand_alu_op(), rand_reg(), rand_reg(), rand_reg(),
                                 11'(rand_bits(11)));
                    if (id == 2) begin
                        w.rj = prev_rd;
                    end else begin
                        // steer the younger word off the older destination
                        if (w.rj == prev_rd) begin
                            w.rj = w.rj ^ 5'd1;
                        end
                        if (w.rk == prev_rd) begin
                            w.rk = w.rk ^ 5'd1;
                        end
                    end
                    add_word(w, 1'b1);
                end
            end
            3: begin
                for (int i = 0; i < 12; i++) begin
                    // even steps chain through r1
                    if (i % 2 == 0) begin
                        w = mk_instr(op_mul, 5'd1, 5'd1, rand_reg(), 11'd0);
                    end else begin
                        w = mk_instr(op_mul, rand_reg(), rand_reg(), rand_reg(), 11'd0);
                    end
                    add_word(w, 1'b1);
                    add_word(mk_instr(rand_alu_op(), rand_reg(), w.rd, rand_reg(),
                                      11'(rand_bits(11))), 1'b1);
                end
            end
            4: begin
                for (int i = 0; i < 24; i++) begin
                    if (rand_bits(2) == 0) begin
                        op = 6'(rand_bits(6)) | 6'h08;
                    end else begin
                        op = rand_alu_op();
                    end
                    add_word(mk_instr(op, rand_reg(), rand_reg(), rand_reg(),
                                      11'(rand_bits(11))), 1'b1);
                end
            end
            5: begin
                for (int i = 0; i < 32; i++) begin
                    case (3'(rand_bits(3)))
                        3'd0:    op = op_nop;
                        3'd1:    op = op_mul;
                        3'd2:    op = 6'(rand_bits(6)) | 6'h08;
                        default: op = rand_alu_op();
                    endcase
                    add_word(mk_instr(op, 5'(rand_bits(3)), 5'(rand_bits(3)),
                                      5'(rand_bits(3)), 11'(rand_bits(11))),
                             rand_bits(2) != 0);
                end
            end
            default: begin
                for (int i = 0; i < 24; i++) begin
                    add_word(mk_instr(rand_alu_op(), rand_reg(), rand_reg(), rand_reg(),
                                      11'(rand_bits(11))), 1'b1);
                end
            end
        endcase
    endfunction

    // reference interpreter runs one program word in order
    function automatic void ref_exec(input int idx);
        instr_t      w;
        event_t      ev;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        if (!prog_v[idx]) begin
            return;
        end
        w  = prog_w[idx];
        a  = mregs[w.rj];
        b  = mregs[w.rk];
        ev = '0;
        case (w.opcode)
            op_nop:  return;
            op_add:  res = a + b;
            op_sub:  res = a - b;
            op_and:  res = a & b;
            op_or:   res = a | b;
            op_xor:  res = a ^ b;
            op_addi: res = a + {{21{w.imm[10]}}, w.imm};
            op_mul: begin
                res       = a * b;
                ev.is_mul = 1'b1;
            end
            default: begin
                ev.is_exc = 1'b1;
                ev.value  = 32'(idx * 4);
                exp_q.push_back(ev);
                return;
            end
        endcase
        ev.rd    = w.rd;
        ev.value = res;
        if (w.rd != '0) begin
            mregs[w.rd] = res;
        end
        exp_q.push_back(ev);
    endfunction

    function automatic void build_expected();
        exp_q.delete();
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        for (int i = 0; i < prog_len; i++) begin
            // words dropped by a flush never run
            if (!(flush_done && i >= flush_k && i < flush_mark)) begin
                ref_exec(i);
            end
        end
    endfunction

    function automatic void report_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        errors++;
    endfunction

    function automatic void check_event(input logic is_exc, input int port,
                                        input logic [4:0] rd, input logic [31:0] value);
        event_t exp;
        if (exp_pos >= exp_q.size()) begin
            report_error($sformatf("unexpected strobe on port %0d, r%0d=%h", port, rd, value));
            return;
        end
        exp = exp_q[exp_pos];
        exp_pos++;
        if (exp.is_exc != is_exc) begin
            report_error($sformatf("strobe %0d is exc=%0b, expected exc=%0b",
                                   exp_pos - 1, is_exc, exp.is_exc));
        end else if (is_exc && value != exp.value) begin
            report_error($sformatf("exception pc %h, expected %h", value, exp.value));
        end else if (!is_exc && (rd != exp.rd || value != exp.value)) begin
            report_error($sformatf("write r%0d=%h, expected r%0d=%h",
                                   rd, value, exp.rd, exp.value));
        end
        if (exp.is_mul && !is_exc) begin
            if (port != 0) begin
                report_error("multiply wrote back on port 1");
            end
            if (cyc - mul_issue_cyc != mul_wb_delay) begin
                report_error($sformatf("multiply wrote back %0d cycles after issue",
                                       cyc - mul_issue_cyc));
            end
        end
    endfunction

    // strobes are compared at the falling edge where outputs have settled
    always @(negedge clk) begin
        cyc++;
        if (rst_n) begin
            if (num_read == 2'b10) begin
                report_error("num_read showed 10");
            end
            if (wb0.valid && wb1.valid) begin
                dual_cnt++;
            end
            if (wb0.valid) begin
                check_event(1'b0, 0, wb0.rd, wb0.data);
            end
            if (exc_valid) begin
                if (exc_code != exc_illegal) begin
                    report_error($sformatf("exception code %0d", exc_code));
                end
                check_event(1'b1, 0, '0, exc_pc);
            end
            if (wb1.valid) begin
                check_event(1'b0, 1, wb1.rd, wb1.data);
            end
            if (issue_core_inst.eu0_en && issue_core_inst.eu0_slot.opcode == op_mul
                && issue_core_inst.eu0_slot.exc == exc_none) begin
                mul_issue_cyc = cyc;
            end
            // strobes seen so far are the words that issued before the flush
            if (flush) begin
                flush_k    = exp_pos;
                flush_done = 1'b1;
                build_expected();
            end
        end
    end

    task automatic present(input int idx);
        fetch_instr0 = (idx < prog_len) ? prog_w[idx] : '0;
        fetch_valid0 = (idx < prog_len) ? prog_v[idx] : 1'b0;
        fetch_pc0    = 32'(idx * 4);
        fetch_instr1 = (idx + 1 < prog_len) ? prog_w[idx + 1] : '0;
        fetch_valid1 = (idx + 1 < prog_len) ? prog_v[idx + 1] : 1'b0;
        fetch_pc1    = 32'((idx + 1) * 4);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        flush = 1'b0;
        present(prog_len);
        repeat (9) @(posedge clk);
        @(negedge clk);
        if (num_read != 2'b11 || wb0.valid || wb1.valid || exc_valid) begin
            report_error("outputs not in their reset state");
        end
        @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    // feeder advances by what num_read reports
    task automatic feed_program(input int flush_cyc);
        int         ptr;
        int         cyc_n;
        logic [1:0] nr;
        ptr   = 0;
        cyc_n = 0;
        while (ptr < prog_len) begin
            present(ptr);
            flush = (cyc_n == flush_cyc);
            @(negedge clk);
            nr = num_read;
            @(posedge clk);
            #2;
            if (flush) begin
                ptr = flush_mark;
            end else if (nr == 2'b11) begin
                ptr += 2;
            end else if (nr == 2'b01) begin
                ptr += 1;
            end
            cyc_n++;
        end
        flush = 1'b0;
        present(prog_len);
    endtask

    task automatic run_test(input int id, input string name, input int flush_cyc);
        int errs_before;
        errs_before = errors;
        build_program(id);
        apply_reset();
        exp_pos       = 0;
        flush_done    = 1'b0;
        flush_k       = 0;
        dual_cnt      = 0;
        mul_issue_cyc = 0;
        build_expected();
        feed_program(flush_cyc);
        while (exp_pos < exp_q.size()) begin
            @(posedge clk);
        end
        // a few idle cycles catch stray write-backs
        repeat (4) @(posedge clk);
        #2;
        // every pair of the independent program issues together
        if (id == 1 && dual_cnt != prog_len / 2) begin
            report_error($sformatf("independent pairs dual-issued %0d times, expected %0d",
                                   dual_cnt, prog_len / 2));
        end
        if (flush_cyc >= 0 && !flush_done) begin
            report_error("flush was never applied");
        end
        if (errors == errs_before) begin
            $display("test %0d %s: ok", id, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", id, name, errors - errs_before);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        flush        = 1'b0;
        fetch_instr0 = '0;
        fetch_instr1 = '0;
        fetch_pc0    = '0;
        fetch_pc1    = '0;
        fetch_valid0 = 1'b0;
        fetch_valid1 = 1'b0;
        prog_len     = 0;
        errors       = 0;
        failed_tests = 0;
        cyc          = 0;
        flush_done   = 1'b0;
        run_test(1, "independent alu pairs", -1);
        run_test(2, "dependent pairs", -1);
        run_test(3, "multiply", -1);
        run_test(4, "illegal opcodes", -1);
        run_test(5, "random bubbles", -1);
        run_test(6, "flush", 6);
        $display("%0d tests, %0d failed, %0d errors", num_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // 40 cycles per program word plus reset time
    initial begin
        #(watchdog_ns);
        $display("timeout: the DUT did not finish the programs in time");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
